//--- all.f
cpu_pkg.sv
instr_decoder.sv
register_file.sv
alu.sv
bus_interface_unit.sv
cpu_core.sv
data_ram.sv
io_port.sv
cpu_top.sv
tb_clock.sv
cpu_asserts.sv
tb_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_top
FILE_LIST ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Done: no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG) && echo "Simulation passed" || \
		(echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb_top.sv
`timescale 1ns/100ps

module tb_top;

    import cpu_pkg::*;

    localparam int          TIMEOUT_CYCLES = 200;  // About 70 instructions plus reset and margin
    localparam int          HALT_WATCH     = 4;    // Cycles watched for stray strobes after halt
    localparam logic [31:0] RANDOM_SEED    = 32'hf5a4_f4bb;
    localparam logic [7:0]  VAL_A          = 8'h5A;
    localparam logic [7:0]  VAL_B          = 8'hC3;
    localparam logic [7:0]  ADDI_IMM       = 8'hF0;
    localparam logic [7:0]  IO_OFFSET      = 8'h25;
    localparam logic [7:0]  LOOP_COUNT     = 8'd3;
    localparam logic [11:0] OUT_ADDR       = 12'h0C1;
    localparam logic [11:0] IN_ADDR        = 12'h0C0;

    logic                   clk;
    logic                   reset;
    logic [INSTR_WIDTH-1:0] instr;
    logic [PC_WIDTH-1:0]    instr_addr;
    logic                   halted;
    logic [DATA_WIDTH-1:0]  in_port;
    logic [DATA_WIDTH-1:0]  out_port;
    logic                   out_strobe;

    logic [INSTR_WIDTH-1:0] rom [4096];
    logic [7:0]             expect_q [$];  // Expected out_port bytes in strobe order
    string                  name_q [$];
    int                     prog_len     = 0;
    int                     io_step      = 0;
    int                     io_slot      = 0;
    int                     strobe_count = 0;
    int                     value_errors = 0;
    int                     other_errors = 0;

    tb_clock clock_i (.clk(clk));

    cpu_top dut_i (
        .clk        (clk),
        .reset      (reset),
        .instr      (instr),
        .instr_addr (instr_addr),
        .halted     (halted),
        .in_port    (in_port),
        .out_port   (out_port),
        .out_strobe (out_strobe)
    );

    bind cpu_top cpu_asserts asserts_i (
        .clk        (clk),
        .reset      (reset),
        .bus_addr   (bus_addr),
        .mem_cs     (mem_cs),
        .io_cs      (io_cs),
        .mem_we     (mem_we),
        .mem_oe     (mem_oe),
        .out_strobe (out_strobe),
        .halted     (halted),
        .instr_addr (instr_addr)
    );

    assign instr = rom[instr_addr];  // Program memory answers in the same cycle

    // ########################################
    // Program and expected output
    // ########################################
    function automatic logic [15:0] reg_word(opcode_t op, logic [1:0] rd, logic [1:0] rs,
                                             logic [7:0] imm8);
        return {op, rd, rs, imm8};
    endfunction

    function automatic logic [15:0] addr_word(opcode_t op, logic [11:0] addr12);
        return {op, addr12};
    endfunction

    task automatic place_word(logic [15:0] word);
        rom[prog_len] = word;
        prog_len++;
    endtask

    task automatic expect_output(string name, logic [7:0] value);
        expect_q.push_back(value);
        name_q.push_back(name);
    endtask

    task automatic store_to_output(string name, logic [7:0] value);
        place_word(addr_word(OP_ST, OUT_ADDR));  // ST always sends r0
        expect_output(name, value);
    endtask

    // r1 holds VAL_B, r0 is reloaded with VAL_A for each operation
    task automatic alu_case(opcode_t op, string name, logic [7:0] value);
        place_word(reg_word(OP_LDI, 2'd0, 2'd0, VAL_A));
        place_word(reg_word(op, 2'd0, 2'd1, 8'h00));
        store_to_output(name, value);
    endtask

    task automatic load_program();
        int loop_top;
        for (int i = 0; i < 4096; i++) begin
            rom[i] = addr_word(OP_JMP, i[11:0]);  // Unused words trap a runaway pc
        end
        place_word(reg_word(OP_LDI, 2'd1, 2'd0, VAL_B));
        alu_case(OP_ADD, "add", VAL_A + VAL_B);
        alu_case(OP_SUB, "sub", VAL_A - VAL_B);
        alu_case(OP_AND, "and", VAL_A & VAL_B);
        alu_case(OP_OR, "or", VAL_A | VAL_B);
        alu_case(OP_XOR, "xor", VAL_A ^ VAL_B);
        place_word(reg_word(OP_ADDI, 2'd0, 2'd0, ADDI_IMM));
        store_to_output("addi", (VAL_A ^ VAL_B) + ADDI_IMM);
        // Code is straight so far, so the address of the load is also its step
        io_step = prog_len;
        place_word(addr_word(OP_LD, IN_ADDR));
        place_word(reg_word(OP_ADDI, 2'd0, 2'd0, IO_OFFSET));
        io_slot = expect_q.size();
        store_to_output("io_read", 8'h00);  // Filled in once the input byte is chosen
        // Direct RAM stores at both ends of the RAM and one unmapped address
        place_word(reg_word(OP_LDI, 2'd0, 2'd0, 8'h11));
        place_word(addr_word(OP_ST, 12'h040));
        place_word(reg_word(OP_LDI, 2'd0, 2'd0, 8'h22));
        place_word(addr_word(OP_ST, 12'h07F));
        place_word(reg_word(OP_LDI, 2'd0, 2'd0, 8'h33));
        place_word(addr_word(OP_ST, 12'h0BF));
        place_word(reg_word(OP_LDI, 2'd0, 2'd0, 8'h44));
        place_word(addr_word(OP_ST, 12'h020));
        place_word(addr_word(OP_LD, 12'h040));
        store_to_output("ram_40", 8'h11);
        place_word(addr_word(OP_LD, 12'h07F));
        store_to_output("ram_7f", 8'h22);
        place_word(addr_word(OP_LD, 12'h0BF));
        store_to_output("ram_bf", 8'h33);
        place_word(reg_word(OP_LDI, 2'd0, 2'd0, 8'h55));  // Nonzero so a zero load shows
        place_word(addr_word(OP_LD, 12'h020));
        store_to_output("unmapped", 8'h00);
        // Indirect access through the r3:r2 pointer
        place_word(reg_word(OP_LDI, 2'd3, 2'd0, 8'h00));
        place_word(reg_word(OP_LDI, 2'd2, 2'd0, 8'h7F));
        place_word(reg_word(OP_LDX, 2'd1, 2'd0, 8'h00));
        place_word(reg_word(OP_MOV, 2'd0, 2'd1, 8'h00));
        store_to_output("ldx_7f", 8'h22);
        place_word(reg_word(OP_LDI, 2'd2, 2'd0, 8'h40));
        place_word(reg_word(OP_LDI, 2'd1, 2'd0, 8'h66));
        place_word(reg_word(OP_STX, 2'd0, 2'd1, 8'h00));
        place_word(addr_word(OP_LD, 12'h040));
        store_to_output("stx_40", 8'h66);
        // Countdown loop with one strobe per pass
        place_word(reg_word(OP_LDI, 2'd1, 2'd0, LOOP_COUNT));
        place_word(reg_word(OP_LDI, 2'd2, 2'd0, 8'h01));
        loop_top = prog_len;
        place_word(reg_word(OP_MOV, 2'd0, 2'd1, 8'h00));
        place_word(addr_word(OP_ST, OUT_ADDR));
        place_word(reg_word(OP_SUB, 2'd1, 2'd2, 8'h00));
        place_word(addr_word(OP_JZ, prog_len[11:0] + 12'd2));
        place_word(addr_word(OP_JMP, loop_top[11:0]));
        for (logic [7:0] n = LOOP_COUNT; n != 8'd0; n--) begin
            expect_output("countdown", n);
        end
        place_word(addr_word(OP_JMP, prog_len[11:0] + 12'd2));
        place_word(addr_word(OP_ST, OUT_ADDR));  // Skipped by the jump
        place_word(reg_word(OP_LDI, 2'd0, 2'd0, 8'h77));
        store_to_output("jmp_skip", 8'h77);
        place_word(addr_word(OP_HALT, 12'h000));
        place_word(addr_word(OP_ST, OUT_ADDR));  // Must never run
    endtask

    // ########################################
    // Output checking
    // ########################################
    always @(posedge clk) begin
        if (!reset && out_strobe) begin
            assert (strobe_count < expect_q.size()) else begin
                other_errors++;
                $display("Unexpected output strobe with out_port 0x%02h", out_port);
            end
            if (strobe_count < expect_q.size()) begin
                assert (out_port == expect_q[strobe_count]) else begin
                    value_errors++;
                    $display("ERR %s: expected 0x%02h, actual 0x%02h",
                             name_q[strobe_count], expect_q[strobe_count], out_port);
                end
            end
            strobe_count++;
        end
    end

    // Step k is the instruction that runs between the k-th edge after reset and the next
    initial begin : stimulus
        logic [31:0] rand_word;
        int          step;
        rand_word = $urandom(RANDOM_SEED);
        reset     = 1'b1;
        in_port   = '0;
        load_program();
        repeat (2) @(posedge clk);
        #2;
        reset = 1'b0;
        step  = 0;
        while (!halted) begin
            rand_word = $urandom;
            in_port   = rand_word[7:0];
            if (step == io_step) begin
                expect_q[io_slot] = rand_word[7:0] + IO_OFFSET;
            end
            @(posedge clk);
            #2;
            step++;
        end
        repeat (HALT_WATCH) @(posedge clk);
        #2;
        assert (strobe_count == expect_q.size()) else begin
            other_errors++;
            $display("Output strobes missing, saw %0d of %0d", strobe_count, expect_q.size());
        end
        assert (dut_i.asserts_i.assert_failures == 0) else begin
            other_errors++;
            $display("Bus protocol assertions failed %0d times",
                     dut_i.asserts_i.assert_failures);
        end
        $display("Summary: %0d strobes, %0d value errors, %0d other errors",
                 strobe_count, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin : watchdog
        int cycle_count;
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        other_errors++;
        $display("Timeout: the core did not halt within %0d cycles", TIMEOUT_CYCLES);
        $display("Summary: %0d strobes, %0d value errors, %0d other errors",
                 strobe_count, value_errors, other_errors);
        $display("Done: errors found");
        $finish;
    end

endmodule

//--- cpu_asserts.sv
`timescale 1ns/100ps

module cpu_asserts (
    input logic                           clk,
    input logic                           reset,
    input logic [cpu_pkg::ADDR_WIDTH-1:0] bus_addr,
    input logic                           mem_cs,
    input logic                           io_cs,
    input logic                           mem_we,
    input logic                           mem_oe,
    input logic                           out_strobe,
    input logic                           halted,
    input logic [cpu_pkg::PC_WIDTH-1:0]   instr_addr
);

    import cpu_pkg::*;

    int assert_failures = 0;  // Number of assertion failures so far

    // The address decode must never select both targets at once
    selects_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(mem_cs && io_cs))
        else begin
            assert_failures++;
            $error("RAM and I/O selects are high together");
        end

    strobe_needs_select: assert property (@(posedge clk) disable iff (reset)
        (mem_we || mem_oe) |-> (mem_cs || io_cs))
        else begin
            assert_failures++;
            $error("Bus strobe without a select");
        end

    // A RAM access carries the offset from the RAM base, which fits in 7 bits
    ram_offset_in_range: assert property (@(posedge clk) disable iff (reset)
        mem_cs |-> (bus_addr[ADDR_WIDTH-1:MEM_ADDR_WIDTH] == '0))
        else begin
            assert_failures++;
            $error("RAM offset outside the RAM depth");
        end

    // A strobe falls after one cycle unless another I/O store ended in it
    strobe_one_cycle: assert property (@(posedge clk) disable iff (reset)
        out_strobe |=> (!out_strobe || $past(io_cs && mem_we)))
        else begin
            assert_failures++;
            $error("Output strobe held longer than one cycle");
        end

    halt_freezes_pc: assert property (@(posedge clk) disable iff (reset)
        halted |=> (halted && $stable(instr_addr)))
        else begin
            assert_failures++;
            $error("Program counter moved after halt");
        end

endmodule

//--- tb_clock.sv
`timescale 1ns/100ps

module tb_clock (
    output logic clk
);

    // 40 ns period, so each phase lasts 20 ns
    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

endmodule

//--- cpu_top.sv
`timescale 1ns/100ps

module cpu_top (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [cpu_pkg::INSTR_WIDTH-1:0] instr,
    output logic [cpu_pkg::PC_WIDTH-1:0]    instr_addr,
    output logic                            halted,
    input  logic [cpu_pkg::DATA_WIDTH-1:0]  in_port,
    output logic [cpu_pkg::DATA_WIDTH-1:0]  out_port,
    output logic                            out_strobe
);

    import cpu_pkg::*;

    // Shared data bus
    logic [ADDR_WIDTH-1:0] bus_addr;
    wire  [DATA_WIDTH-1:0] bus_data;
    logic                  mem_cs;
    logic                  mem_we;
    logic                  mem_oe;
    logic                  io_cs;

    cpu_core core_i (
        .clk        (clk),
        .reset      (reset),
        .instr      (instr),
        .instr_addr (instr_addr),
        .halted     (halted),
        .bus_addr   (bus_addr),
        .bus_data   (bus_data),
        .mem_cs     (mem_cs),
        .mem_we     (mem_we),
        .mem_oe     (mem_oe),
        .io_cs      (io_cs)
    );

    data_ram ram_i (
        .clk  (clk),
        .cs   (mem_cs),
        .we   (mem_we),
        .oe   (mem_oe),
        .addr (bus_addr[MEM_ADDR_WIDTH-1:0]),  // Offset from the RAM base
        .data (bus_data)
    );

    // The port has one address so it ignores the bus offset
    io_port io_i (
        .clk        (clk),
        .reset      (reset),
        .cs         (io_cs),
        .we         (mem_we),
        .data       (bus_data),
        .in_port    (in_port),
        .out_port   (out_port),
        .out_strobe (out_strobe)
    );

endmodule

//--- io_port.sv
`timescale 1ns/100ps

module io_port (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           cs,
    input  logic                           we,
    inout  wire  [cpu_pkg::DATA_WIDTH-1:0] data,
    input  logic [cpu_pkg::DATA_WIDTH-1:0] in_port,
    output logic [cpu_pkg::DATA_WIDTH-1:0] out_port,
    output logic                           out_strobe
);

    always_ff @(posedge clk) begin
        if (reset) begin
            out_port   <= '0;
            out_strobe <= 1'b0;
        end else begin
            out_strobe <= cs && we;  // High for the cycle after the store edge
            if (cs && we) begin
                out_port <= data;
            end
        end
    end

    // Any selected access that is not a write is a read of the input byte
    assign data = (cs && !we) ? in_port : 'z;

endmodule

//--- data_ram.sv
`timescale 1ns/100ps

module data_ram (
    input  logic                               clk,
    input  logic                               cs,
    input  logic                               we,
    input  logic                               oe,
    input  logic [cpu_pkg::MEM_ADDR_WIDTH-1:0] addr,
    inout  wire  [cpu_pkg::DATA_WIDTH-1:0]     data
);

    import cpu_pkg::*;

    logic [DATA_WIDTH-1:0] mem [MEM_DEPTH];

    always_ff @(posedge clk) begin
        if (cs && we) begin
            mem[addr] <= data;
        end
    end

    // Read data is on the bus in the same cycle as the address
    assign data = (cs && oe) ? mem[addr] : 'z;

endmodule

//--- cpu_core.sv
`timescale 1ns/100ps

module cpu_core (
    input  logic                             clk,
    input  logic                             reset,
    input  logic [cpu_pkg::INSTR_WIDTH-1:0]  instr,
    output logic [cpu_pkg::PC_WIDTH-1:0]     instr_addr,
    output logic                             halted,
    output logic [cpu_pkg::ADDR_WIDTH-1:0]   bus_addr,
    inout  wire  [cpu_pkg::DATA_WIDTH-1:0]   bus_data,
    output logic                             mem_cs,
    output logic                             mem_we,
    output logic                             mem_oe,
    output logic                             io_cs
);

    import cpu_pkg::*;

    opcode_t                 opcode;
    alu_op_t                 alu_op;
    logic [GROUP_COUNT-1:0]  opcode_group;
    logic [SIGNAL_COUNT-1:0] signals;
    logic [SIGNAL_COUNT-1:0] bus_signals;
    logic [11:0]             imm12;
    logic [7:0]              imm8;
    logic [1:0]              rd;
    logic [1:0]              rs;
    logic [1:0]              write_sel;
    logic [1:0]              read_sel_b;
    logic [DATA_WIDTH-1:0]   read_a;
    logic [DATA_WIDTH-1:0]   read_b;
    logic [DATA_WIDTH-1:0]   alu_b;
    logic [DATA_WIDTH-1:0]   alu_result;
    logic [DATA_WIDTH-1:0]   load_data;
    logic [DATA_WIDTH-1:0]   write_data;
    logic [ADDR_WIDTH-1:0]   page_addr;
    logic [PC_WIDTH-1:0]     pc;
    logic                    alu_zero;
    logic                    zero_flag;
    logic                    take_jump;

    // Instruction fields
    assign opcode = opcode_t'(instr[15:12]);
    assign rd     = instr[11:10];
    assign rs     = instr[9:8];
    assign imm8   = instr[7:0];
    assign imm12  = instr[11:0];

    // ########################################
    // Program counter, zero flag and halt
    // ########################################
    assign take_jump  = opcode_group[GROUP_JUMP] && (opcode == OP_JMP || zero_flag);
    assign instr_addr = pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc        <= '0;
            zero_flag <= 1'b0;
            halted    <= 1'b0;
        end else if (!halted) begin
            if (opcode_group[GROUP_HALT]) begin
                halted <= 1'b1;  // pc stays on the HALT word
            end else begin
                pc <= take_jump ? imm12 : pc + 1'b1;
            end
            if (signals[CONTROL_FLAG_WRITE]) zero_flag <= alu_zero;
        end
    end

    // Keep the data bus quiet during reset and once halted
    assign bus_signals = (reset || halted) ? '0 : signals;

    // LD always targets r0 and ST always sources r0
    assign write_sel  = opcode_group[GROUP_LOAD_DIRECT] ? 2'd0 : rd;
    assign read_sel_b = opcode_group[GROUP_STORE_DIRECT] ? 2'd0 : rs;
    assign alu_b      = signals[CONTROL_ALU_SRC_IMM] ? imm8 : read_b;
    assign write_data = signals[CONTROL_MEM_READ] ? load_data : alu_result;

    instr_decoder decoder_i (
        .opcode       (opcode),
        .opcode_group (opcode_group),
        .signals      (signals),
        .alu_op       (alu_op)
    );

    register_file regs_i (
        .clk        (clk),
        .reset      (reset),
        .write_en   (signals[CONTROL_REG_WRITE] && !halted),
        .write_sel  (write_sel),
        .write_data (write_data),
        .read_sel_a (rd),
        .read_sel_b (read_sel_b),
        .read_a     (read_a),
        .read_b     (read_b),
        .page_addr  (page_addr)
    );

    alu alu_i (
        .op     (alu_op),
        .a      (read_a),
        .b      (alu_b),
        .result (alu_result),
        .zero   (alu_zero)
    );

    bus_interface_unit biu_i (
        .opcode_group  (opcode_group),
        .opcode_imd    (imm12),
        .signals       (bus_signals),
        .data_to_store (read_b),
        .indirect_addr (page_addr),
        .bus_addr      (bus_addr),
        .bus_data      (bus_data),
        .mem_cs        (mem_cs),
        .mem_we        (mem_we),
        .mem_oe        (mem_oe),
        .io_cs         (io_cs),
        .load_data     (load_data)
    );

endmodule

//--- bus_interface_unit.sv
`timescale 1ns/100ps

module bus_interface_unit (
    input  logic [cpu_pkg::GROUP_COUNT-1:0]  opcode_group,
    input  logic [11:0]                      opcode_imd,
    input  logic [cpu_pkg::SIGNAL_COUNT-1:0] signals,
    input  logic [cpu_pkg::DATA_WIDTH-1:0]   data_to_store,
    input  logic [cpu_pkg::ADDR_WIDTH-1:0]   indirect_addr,
    output logic [cpu_pkg::ADDR_WIDTH-1:0]   bus_addr,
    inout  wire  [cpu_pkg::DATA_WIDTH-1:0]   bus_data,
    output logic                             mem_cs,
    output logic                             mem_we,
    output logic                             mem_oe,
    output logic                             io_cs,
    output logic [cpu_pkg::DATA_WIDTH-1:0]   load_data
);

    import cpu_pkg::*;

    logic [ADDR_WIDTH-1:0] access_addr;
    logic                  uses_indirect;
    logic                  should_load;
    logic                  should_store;
    logic                  any_access;

    assign should_load   = signals[CONTROL_MEM_READ];
    assign should_store  = signals[CONTROL_MEM_WRITE];
    assign any_access    = should_load || should_store;
    assign uses_indirect = opcode_group[GROUP_LOAD_INDIRECT] ||
                           opcode_group[GROUP_STORE_INDIRECT];

    // Direct forms carry a 12-bit address, zero extended onto the 16-bit bus
    assign access_addr = uses_indirect ? indirect_addr : {4'b0, opcode_imd};

    // ########################################
    // Address decode and strobes
    // ########################################
    assign mem_cs = any_access && (access_addr >= MEM_START_ADDR) &&
                    (access_addr <= MEM_STOP_ADDR);
    assign io_cs  = any_access && (access_addr >= IO_START_ADDR) &&
                    (access_addr <= IO_STOP_ADDR);
    assign mem_we = (mem_cs || io_cs) && should_store;  // Unmapped stores never strobe
    assign mem_oe = (mem_cs || io_cs) && should_load;

    assign bus_addr = mem_cs ? access_addr - MEM_START_ADDR :
                      io_cs  ? access_addr - IO_START_ADDR  : '0;

    // The core is the only store driver on the shared bus
    assign bus_data  = should_store ? data_to_store : 'z;
    assign load_data = (mem_cs || io_cs) ? bus_data : '0;  // Unmapped loads read as 0

endmodule

//--- alu.sv
`timescale 1ns/100ps

module alu (
    input  cpu_pkg::alu_op_t               op,
    input  logic [cpu_pkg::DATA_WIDTH-1:0] a,
    input  logic [cpu_pkg::DATA_WIDTH-1:0] b,
    output logic [cpu_pkg::DATA_WIDTH-1:0] result,
    output logic                           zero
);

    import cpu_pkg::*;

    // All arithmetic wraps at 8 bits, there is no carry out
    always_comb begin
        case (op)
            ALU_ADD: result = a + b;
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_XOR: result = a ^ b;
            default: result = b;  // Pass operand b
        endcase
    end

    assign zero = (result == '0);

endmodule

//--- register_file.sv
`timescale 1ns/100ps

module register_file (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            write_en,
    input  logic [1:0]                      write_sel,
    input  logic [cpu_pkg::DATA_WIDTH-1:0]  write_data,
    input  logic [1:0]                      read_sel_a,
    input  logic [1:0]                      read_sel_b,
    output logic [cpu_pkg::DATA_WIDTH-1:0]  read_a,
    output logic [cpu_pkg::DATA_WIDTH-1:0]  read_b,
    output logic [cpu_pkg::ADDR_WIDTH-1:0]  page_addr
);

    import cpu_pkg::*;

    logic [DATA_WIDTH-1:0] regs [4];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 4; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en) begin
            regs[write_sel] <= write_data;
        end
    end

    assign read_a = regs[read_sel_a];
    assign read_b = regs[read_sel_b];

    // r3 is the high byte of the indirect pointer, r2 the low byte
    assign page_addr = {regs[3], regs[2]};

endmodule

//--- instr_decoder.sv
`timescale 1ns/100ps

module instr_decoder (
    input  cpu_pkg::opcode_t                 opcode,
    output logic [cpu_pkg::GROUP_COUNT-1:0]  opcode_group,
    output logic [cpu_pkg::SIGNAL_COUNT-1:0] signals,
    output cpu_pkg::alu_op_t                 alu_op
);

    import cpu_pkg::*;

    // Group and control bits
    always_comb begin
        opcode_group = '0;
        signals      = '0;
        case (opcode)
            OP_LDI: begin
                opcode_group[GROUP_LOAD_IMMEDIATE] = 1'b1;
                signals[CONTROL_REG_WRITE]         = 1'b1;
                signals[CONTROL_ALU_SRC_IMM]       = 1'b1;  // imm8 passes straight through
            end
            OP_MOV, OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADDI: begin
                opcode_group[GROUP_ALU]      = 1'b1;
                signals[CONTROL_REG_WRITE]   = 1'b1;
                signals[CONTROL_FLAG_WRITE]  = 1'b1;
                signals[CONTROL_ALU_SRC_IMM] = (opcode == OP_ADDI);
            end
            OP_LD: begin
                opcode_group[GROUP_LOAD_DIRECT] = 1'b1;
                signals[CONTROL_REG_WRITE]      = 1'b1;
                signals[CONTROL_MEM_READ]       = 1'b1;
            end
            OP_ST: begin
                opcode_group[GROUP_STORE_DIRECT] = 1'b1;
                signals[CONTROL_MEM_WRITE]       = 1'b1;
            end
            OP_LDX: begin
                opcode_group[GROUP_LOAD_INDIRECT] = 1'b1;
                signals[CONTROL_REG_WRITE]        = 1'b1;
                signals[CONTROL_MEM_READ]         = 1'b1;
            end
            OP_STX: begin
                opcode_group[GROUP_STORE_INDIRECT] = 1'b1;
                signals[CONTROL_MEM_WRITE]         = 1'b1;
            end
            OP_JMP, OP_JZ: opcode_group[GROUP_JUMP] = 1'b1;  // Core tells the two apart
            OP_HALT:       opcode_group[GROUP_HALT] = 1'b1;
            default: ;  // NOP belongs to no group
        endcase
    end

    // ALU operation
    always_comb begin
        case (opcode)
            OP_ADD, OP_ADDI: alu_op = ALU_ADD;
            OP_SUB:          alu_op = ALU_SUB;
            OP_AND:          alu_op = ALU_AND;
            OP_OR:           alu_op = ALU_OR;
            OP_XOR:          alu_op = ALU_XOR;
            default:         alu_op = ALU_PASS_B;  // LDI and MOV just forward operand b
        endcase
    end

endmodule

//--- cpu_pkg.sv
package cpu_pkg;

    // ########################################
    // Widths
    // ########################################
    localparam int DATA_WIDTH  = 8;
    localparam int ADDR_WIDTH  = 16;  // Full 64 KB data space, only the low page is mapped
    localparam int PC_WIDTH    = 12;
    localparam int INSTR_WIDTH = 16;

    // ########################################
    // Data bus address map
    // ########################################
    localparam logic [ADDR_WIDTH-1:0] MEM_START_ADDR = 16'h0040;
    localparam logic [ADDR_WIDTH-1:0] MEM_STOP_ADDR  = 16'h00BF;
    localparam logic [ADDR_WIDTH-1:0] IO_START_ADDR  = 16'h00C0;
    localparam logic [ADDR_WIDTH-1:0] IO_STOP_ADDR   = 16'h00FF;
    localparam int MEM_DEPTH      = 128;
    localparam int MEM_ADDR_WIDTH = $clog2(MEM_DEPTH);  // RAM side address bits

    // One-hot opcode group indices
    localparam int GROUP_COUNT          = 8;
    localparam int GROUP_ALU            = 0;
    localparam int GROUP_LOAD_IMMEDIATE = 1;
    localparam int GROUP_LOAD_DIRECT    = 2;
    localparam int GROUP_STORE_DIRECT   = 3;
    localparam int GROUP_LOAD_INDIRECT  = 4;
    localparam int GROUP_STORE_INDIRECT = 5;
    localparam int GROUP_JUMP           = 6;
    localparam int GROUP_HALT           = 7;

    // Control signal indices
    localparam int SIGNAL_COUNT        = 5;
    localparam int CONTROL_REG_WRITE   = 0;
    localparam int CONTROL_MEM_READ    = 1;
    localparam int CONTROL_MEM_WRITE   = 2;
    localparam int CONTROL_ALU_SRC_IMM = 3;  // Operand b comes from imm8 instead of rs
    localparam int CONTROL_FLAG_WRITE  = 4;

    // Opcode lives in instr[15:12]
    typedef enum logic [3:0] {
        OP_NOP, OP_LDI, OP_MOV, OP_ADD,
        OP_SUB, OP_AND, OP_OR,  OP_XOR,
        OP_ADDI, OP_LD, OP_ST,  OP_LDX,
        OP_STX, OP_JMP, OP_JZ,  OP_HALT
    } opcode_t;

    typedef enum logic [2:0] {
        ALU_PASS_B,
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR
    } alu_op_t;

endpackage
